// File: vlog.f
+incdir+include
src/rv32i_pkg.sv
src/cache_pkg.sv
src/bus_adapter.sv
src/cache_way.sv
src/cache_control.sv
src/cache.sv
dv/pmem_model.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
# build the cache testbench with Verilator, run it, and decide on the log

rm -f sim.log

verilator --binary --timing --top-module cache_tb -f vlog.f -o cache_sim &&
./obj_dir/cache_sim > sim.log 2>&1 ||
{ cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "No errors" sim.log && exit 0 || exit 1

// File: dv/cache_patterns.txt
// kind address wdata byte_enable expect keep; kind 1=write 10=fill due 100=write-back due
// keep picks expect bytes, others are memory background; write-back rows: wdata=line, be=word
00000010 00001024 00000000 00000000 00000000 00000000
00000000 00001024 00000000 00000000 00000000 00000000
00000001 00001024 deadbeef 00000003 00000000 00000000
00000000 00001024 00000000 00000000 0000beef 00000003
00000010 00001128 00000000 00000000 00000000 00000000
00000000 00001024 00000000 00000000 0000beef 00000003
00000000 00001128 00000000 00000000 00000000 00000000
// third tag in set 1 pushes out the dirty line
00000110 0000122c 00001020 00000001 0000beef 00000003
00000010 00001024 00000000 00000000 0000beef 00000003
00000000 00001020 00000000 00000000 00000000 00000000
00000000 0000122c 00000000 00000000 00000000 00000000
// set 2, write miss then partial write
00000011 00002044 11223344 0000000f 00000000 00000000
00000001 00002044 aabbccdd 00000004 00000000 00000000
00000000 00002044 00000000 00000000 11bb3344 0000000f
00000000 00002048 00000000 00000000 00000000 00000000
00000010 00002144 00000000 00000000 00000000 00000000
00000110 00002244 00002040 00000001 11bb3344 0000000f
00000010 00002044 00000000 00000000 11bb3344 0000000f
// set 3, single byte writes
00000011 00003060 5a000000 00000008 00000000 00000000
00000000 00003060 00000000 00000000 5a000000 00000008
00000001 00003060 000000a5 00000001 00000000 00000000
00000000 00003060 00000000 00000000 5a0000a5 00000009
00000000 0000307c 00000000 00000000 00000000 00000000
// set 0, cold
00000010 00000000 00000000 00000000 00000000 00000000
00000000 0000001c 00000000 00000000 00000000 00000000

// File: include/lcg_pattern.svh
/* Memory background pattern */

// one step of the linear congruential generator
function automatic logic [31:0] lcg_next(logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// word stored at a byte address before any write reaches memory
function automatic logic [31:0] background_word(logic [31:0] addr);
    return addr ^ lcg_next(32'h6d36_5758 ^ {2'b00, addr[31:2]});
endfunction

// File: dv/cache_tb.sv
/* Cache testbench */

module cache_tb;
    import rv32i_pkg::*;
    import cache_pkg::*;
    `include "lcg_pattern.svh"

    localparam int n_rows       = 25;
    localparam int n_cols       = 6;
    localparam int reset_cycles = 4;
    localparam int cycle_limit  = n_rows * 40 + reset_cycles + 10;

    logic      clk;
    logic      rst_n;
    mem_req_t  cpu_req;
    logic      mem_resp;
    rv32i_word mem_rdata;
    pmem_req_t pmem_req;
    line_t     pmem_rdata;
    logic      pmem_resp;

    logic [31:0] rows [n_rows * n_cols];

    int        cycles       = 0;
    int        errors       = 0;
    int        failed_tests = 0;
    int        fills        = 0;
    int        write_backs  = 0;
    pmem_req_t wb_seen;

    cache #(
        .s_index (3)
    ) u_cache (
        .clk        (clk),
        .rst_n      (rst_n),
        .cpu_req    (cpu_req),
        .mem_resp   (mem_resp),
        .mem_rdata  (mem_rdata),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp)
    );

    pmem_model #(
        .latency (3)
    ) u_pmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .pmem_req   (pmem_req),
        .pmem_rdata (pmem_rdata),
        .pmem_resp  (pmem_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles, the cache stopped answering", cycles);
            $display("Errors found");
            $finish;
        end
    end

    // memory traffic seen between the clock edges
    always @(negedge clk) begin
        if (pmem_resp && pmem_req.read) begin
            fills = fills + 1;
        end
        if (pmem_resp && pmem_req.write) begin
            write_backs = write_backs + 1;
            wb_seen     = pmem_req;
        end
    end

    // background word with the kept bytes taken from value
    function automatic rv32i_word merge_word(rv32i_word addr, rv32i_word value,
                                             logic [3:0] keep);
        rv32i_word w;
        w = background_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (keep[b]) begin
                w[8*b +: 8] = value[8*b +: 8];
            end
        end
        return w;
    endfunction

    function automatic pmem_req_t expected_write_back(rv32i_word line_addr, int word_idx,
                                                      rv32i_word value, logic [3:0] keep);
        pmem_req_t req;
        req.read    = 1'b0;
        req.write   = 1'b1;
        req.address = line_addr;
        for (int w = 0; w < 8; w++) begin
            req.wdata[32*w +: 32] = merge_word(line_addr + 32'(w * 4), value,
                                               (w == word_idx) ? keep : 4'h0);
        end
        return req;
    endfunction

    task automatic check_word(string name, rv32i_word expected, rv32i_word actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_pmem(string name, pmem_req_t expected, pmem_req_t actual);
        if (expected !== actual) begin
            $display("[ERROR] %s expected %h actual %h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic apply_row(int r);
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] be;
        logic [31:0] expect_word;
        logic [31:0] keep;
        string       name;
        int          errors_before;
        int          fills_before;
        int          wbs_before;
        int          waits;
        logic        done;
        rv32i_word   got;
        kind          = rows[r * n_cols];
        addr          = rows[r * n_cols + 1];
        wdata         = rows[r * n_cols + 2];
        be            = rows[r * n_cols + 3];
        expect_word   = rows[r * n_cols + 4];
        keep          = rows[r * n_cols + 5];
        name          = $sformatf("row%0d_%s_%h", r, kind[0] ? "write" : "read", addr);
        errors_before = errors;
        fills_before  = fills;
        wbs_before    = write_backs;
        waits         = 0;
        done          = 1'b0;
        got           = '0;

        cpu_req.read        = !kind[0];
        cpu_req.write       = kind[0];
        cpu_req.byte_enable = be[3:0];
        cpu_req.address     = addr;
        cpu_req.wdata       = wdata;

        while (!done) begin
            @(negedge clk);
            waits++;
            if (mem_resp) begin
                done = 1'b1;
                got  = mem_rdata;
            end
        end
        @(posedge clk);
        #10;
        cpu_req = '0;

        // a hit answers in the cycle after idle
        if (!kind[4] && waits != 2) begin
            $display("%s: hit took %0d cycles instead of 2", name, waits);
            errors++;
        end
        if ((fills - fills_before) != (kind[4] ? 1 : 0)) begin
            $display("%s: expected %0d line fills but saw %0d", name,
                     kind[4] ? 1 : 0, fills - fills_before);
            errors++;
        end
        if (kind[8]) begin
            if (write_backs - wbs_before != 1) begin
                $display("%s: no dirty line write-back was seen", name);
                errors++;
            end else begin
                check_pmem(name, expected_write_back(wdata, int'(be[2:0]), expect_word,
                                                     keep[3:0]), wb_seen);
            end
        end else if (write_backs != wbs_before) begin
            $display("%s: a write-back happened where none was due", name);
            errors++;
        end
        if (!kind[0]) begin
            if (kind[8]) begin
                check_word(name, background_word(addr), got);
            end else begin
                check_word(name, merge_word(addr, expect_word, keep[3:0]), got);
            end
        end

        if (errors == errors_before) begin
            $display("%s ok", name);
        end else begin
            $display("%s FAIL", name);
            failed_tests++;
        end
    endtask

    initial begin
        rst_n   = 1'b0;
        cpu_req = '0;
        $readmemh("dv/cache_patterns.txt", rows);

        repeat (reset_cycles) @(posedge clk);
        #10;
        rst_n = 1'b1;

        @(negedge clk);
        if (mem_resp || pmem_req.read || pmem_req.write) begin
            $display("reset: response or memory request is high after reset");
            errors++;
            failed_tests++;
            $display("reset FAIL");
        end else begin
            $display("reset ok");
        end

        @(posedge clk);
        #10;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end

        $display("tests %0d, failed %0d, errors %0d", n_rows + 1, failed_tests, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule : cache_tb

// File: dv/pmem_model.sv
/* Line memory model */

module pmem_model #(
    parameter int latency = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  cache_pkg::pmem_req_t pmem_req,
    output cache_pkg::line_t     pmem_rdata,
    output logic                 pmem_resp
);
    import cache_pkg::*;
    `include "lcg_pattern.svh"

    localparam int n_lines = 1024;

    line_t      mem [n_lines];
    int         count;
    logic [9:0] line_idx;

    assign line_idx = pmem_req.address[14:5];

    // every word starts as its own address mixed with the lcg pattern
    initial begin
        for (int i = 0; i < n_lines; i++) begin
            for (int w = 0; w < 8; w++) begin
                mem[i][32*w +: 32] = background_word(32'(i * 32 + w * 4));
            end
        end
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            pmem_resp  <= 1'b0;
            pmem_rdata <= '0;
            count      <= 0;
        end else if (pmem_resp) begin
            // one-cycle pulse before the next request
            pmem_resp <= 1'b0;
            count     <= 0;
        end else if (pmem_req.read || pmem_req.write) begin
            if (count == latency - 1) begin
                pmem_resp  <= 1'b1;
                pmem_rdata <= mem[line_idx];
                if (pmem_req.write) begin
                    mem[line_idx] <= pmem_req.wdata;
                end
            end else begin
                count <= count + 1;
            end
        end else begin
            count <= 0;
        end
    end

endmodule : pmem_model

// File: src/cache.sv
/* Two-way write-back cache */

module cache #(
    parameter int s_index = 3
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  rv32i_pkg::mem_req_t  cpu_req,
    output logic                 mem_resp,
    output rv32i_pkg::rv32i_word mem_rdata,
    output cache_pkg::pmem_req_t pmem_req,
    input  cache_pkg::line_t     pmem_rdata,
    input  logic                 pmem_resp
);
    import cache_pkg::*;

    localparam int s_tag = 32 - offset_bits - s_index;

    // request address fields
    logic [s_index-1:0] index;
    logic [s_tag-1:0]   tag;
    logic [2:0]         word_sel;

    way_status_t status0;
    way_status_t status1;
    line_t       line0;
    line_t       line1;
    line_t       sel_line;
    line_t       way_wdata;
    line_be_t    way_be;
    line_t       cpu_line;
    line_be_t    cpu_be;

    logic load_data0;
    logic load_tag0;
    logic set_dirty0;
    logic clear_dirty0;
    logic load_data1;
    logic load_tag1;
    logic set_dirty1;
    logic clear_dirty1;

    assign index    = cpu_req.address[offset_bits +: s_index];
    assign tag      = cpu_req.address[31 -: s_tag];
    assign word_sel = cpu_req.address[offset_bits-1:2];

    cache_way #(
        .s_index (s_index)
    ) u_way0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (index),
        .tag         (tag),
        .load_data   (load_data0),
        .load_tag    (load_tag0),
        .set_dirty   (set_dirty0),
        .clear_dirty (clear_dirty0),
        .wdata       (way_wdata),
        .byte_enable (way_be),
        .status      (status0),
        .line        (line0)
    );

    cache_way #(
        .s_index (s_index)
    ) u_way1 (
        .clk         (clk),
        .rst_n       (rst_n),
        .index       (index),
        .tag         (tag),
        .load_data   (load_data1),
        .load_tag    (load_tag1),
        .set_dirty   (set_dirty1),
        .clear_dirty (clear_dirty1),
        .wdata       (way_wdata),
        .byte_enable (way_be),
        .status      (status1),
        .line        (line1)
    );

    cache_control #(
        .s_index (s_index)
    ) u_control (
        .clk          (clk),
        .rst_n        (rst_n),
        .cpu_req      (cpu_req),
        .status0      (status0),
        .status1      (status1),
        .line0        (line0),
        .line1        (line1),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp),
        .cpu_line     (cpu_line),
        .cpu_be       (cpu_be),
        .load_data0   (load_data0),
        .load_tag0    (load_tag0),
        .set_dirty0   (set_dirty0),
        .clear_dirty0 (clear_dirty0),
        .load_data1   (load_data1),
        .load_tag1    (load_tag1),
        .set_dirty1   (set_dirty1),
        .clear_dirty1 (clear_dirty1),
        .way_wdata    (way_wdata),
        .way_be       (way_be),
        .sel_line     (sel_line),
        .mem_resp     (mem_resp),
        .pmem_req     (pmem_req)
    );

    // word view of the hit line, line view of the cpu word
    bus_adapter u_adapter (
        .line_in          (sel_line),
        .wdata            (cpu_req.wdata),
        .byte_enable      (cpu_req.byte_enable),
        .word_sel         (word_sel),
        .wdata_line       (cpu_line),
        .rdata            (mem_rdata),
        .byte_enable_line (cpu_be)
    );

endmodule : cache

// File: src/cache_control.sv
/* Cache controller */

module cache_control #(
    parameter int s_index = 3
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  rv32i_pkg::mem_req_t    cpu_req,
    input  cache_pkg::way_status_t status0,
    input  cache_pkg::way_status_t status1,
    input  cache_pkg::line_t       line0,
    input  cache_pkg::line_t       line1,
    input  cache_pkg::line_t       pmem_rdata,
    input  logic                   pmem_resp,
    input  cache_pkg::line_t       cpu_line,
    input  cache_pkg::line_be_t    cpu_be,
    output logic                   load_data0,
    output logic                   load_tag0,
    output logic                   set_dirty0,
    output logic                   clear_dirty0,
    output logic                   load_data1,
    output logic                   load_tag1,
    output logic                   set_dirty1,
    output logic                   clear_dirty1,
    output cache_pkg::line_t       way_wdata,
    output cache_pkg::line_be_t    way_be,
    output cache_pkg::line_t       sel_line,
    output logic                   mem_resp,
    output cache_pkg::pmem_req_t   pmem_req
);
    import rv32i_pkg::*;
    import cache_pkg::*;

    localparam int s_tag    = 32 - offset_bits - s_index;
    localparam int num_sets = 2 ** s_index;

    typedef enum logic [1:0] {
        st_idle,
        st_compare,
        st_write_back,
        st_fill
    } state_t;

    state_t state;
    state_t state_next;

    // one bit per set, names the least recently used way
    logic [num_sets-1:0] lru;

    logic [s_index-1:0] index;
    logic [s_tag-1:0]   req_tag;
    logic [s_tag-1:0]   victim_tag;
    logic               access;
    logic               hit;
    logic               hit_way;
    logic               victim;
    logic               victim_dirty;
    rv32i_word          wb_addr;
    rv32i_word          fill_addr;

    // strobes before the per-way split
    logic               target_way;
    logic               load_data;
    logic               load_tag;
    logic               set_dirty;
    logic               clear_dirty;

    assign access  = cpu_req.read | cpu_req.write;
    assign index   = cpu_req.address[offset_bits +: s_index];
    assign req_tag = cpu_req.address[31 -: s_tag];

    assign hit     = status0.hit | status1.hit;
    assign hit_way = status1.hit;

    // empty ways are filled first, else lru decides
    always_comb begin
        if (!status0.valid) begin
            victim = 1'b0;
        end else if (!status1.valid) begin
            victim = 1'b1;
        end else begin
            victim = lru[index];
        end
    end

    assign victim_dirty = victim ? status1.dirty : status0.dirty;
    assign victim_tag   = victim ? status1.tag[s_tag-1:0] : status0.tag[s_tag-1:0];

    assign wb_addr   = {victim_tag, index, {offset_bits{1'b0}}};
    assign fill_addr = {req_tag, index, {offset_bits{1'b0}}};

    assign sel_line = hit_way ? line1 : line0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lru <= '0;
        end else if (state == st_compare && hit) begin
            lru[index] <= ~hit_way;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (access) begin
                    state_next = st_compare;
                end
            end
            st_compare: begin
                if (hit) begin
                    state_next = st_idle;
                end else if (victim_dirty) begin
                    state_next = st_write_back;
                end else begin
                    state_next = st_fill;
                end
            end
            st_write_back: begin
                if (pmem_resp) begin
                    state_next = st_fill;
                end
            end
            st_fill: begin
                if (pmem_resp) begin
                    state_next = st_compare;
                end
            end
            default: state_next = st_idle;
        endcase
    end

    always_comb begin
        mem_resp         = 1'b0;
        load_data        = 1'b0;
        load_tag         = 1'b0;
        set_dirty        = 1'b0;
        clear_dirty      = 1'b0;
        target_way       = victim;
        pmem_req.read    = 1'b0;
        pmem_req.write   = 1'b0;
        pmem_req.address = fill_addr;
        pmem_req.wdata   = victim ? line1 : line0;
        case (state)
            st_compare: begin
                target_way = hit_way;
                if (hit) begin
                    mem_resp = 1'b1;
                    // write hit lands in the response cycle
                    load_data = cpu_req.write;
                    set_dirty = cpu_req.write;
                end
            end
            st_write_back: begin
                pmem_req.write   = 1'b1;
                pmem_req.address = wb_addr;
            end
            st_fill: begin
                pmem_req.read = 1'b1;
                load_data     = pmem_resp;
                load_tag      = pmem_resp;
                clear_dirty   = pmem_resp;
            end
            default: ;
        endcase
    end

    // fill takes the whole memory line, cpu writes only their bytes
    assign way_wdata = (state == st_fill) ? pmem_rdata : cpu_line;
    assign way_be    = (state == st_fill) ? '1 : cpu_be;

    assign load_data0   = load_data & ~target_way;
    assign load_tag0    = load_tag & ~target_way;
    assign set_dirty0   = set_dirty & ~target_way;
    assign clear_dirty0 = clear_dirty & ~target_way;
    assign load_data1   = load_data & target_way;
    assign load_tag1    = load_tag & target_way;
    assign set_dirty1   = set_dirty & target_way;
    assign clear_dirty1 = clear_dirty & target_way;

endmodule : cache_control

// File: src/cache_way.sv
/* One cache way */

module cache_way #(
    parameter int s_index = 3
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [s_index-1:0]                     index,
    input  logic [31-cache_pkg::offset_bits-s_index:0] tag,
    input  logic                                   load_data,
    input  logic                                   load_tag,
    input  logic                                   set_dirty,
    input  logic                                   clear_dirty,
    input  cache_pkg::line_t                       wdata,
    input  cache_pkg::line_be_t                    byte_enable,
    output cache_pkg::way_status_t                 status,
    output cache_pkg::line_t                       line
);
    import cache_pkg::*;

    localparam int s_tag    = 32 - offset_bits - s_index;
    localparam int num_sets = 2 ** s_index;

    logic [s_tag-1:0]    tag_arr  [num_sets];
    line_t               data_arr [num_sets];
    logic [num_sets-1:0] valid_arr;
    logic [num_sets-1:0] dirty_arr;

    // byte-masked line write
    always_ff @(posedge clk) begin
        if (load_data) begin
            for (int i = 0; i < $bits(line_be_t); i++) begin
                if (byte_enable[i]) begin
                    data_arr[index][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_tag) begin
            tag_arr[index] <= tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_arr <= '0;
            dirty_arr <= '0;
        end else begin
            if (load_tag) begin
                valid_arr[index] <= 1'b1;
            end
            // set wins, only one of them is raised per cycle anyway
            if (set_dirty) begin
                dirty_arr[index] <= 1'b1;
            end else if (clear_dirty) begin
                dirty_arr[index] <= 1'b0;
            end
        end
    end

    // lookup at the request index
    always_comb begin
        status.valid = valid_arr[index];
        status.dirty = dirty_arr[index];
        status.tag   = max_tag_bits'(tag_arr[index]);
        status.hit   = valid_arr[index] && (tag_arr[index] == tag);
    end

    assign line = data_arr[index];

endmodule : cache_way

// File: src/bus_adapter.sv
/* Word to line bus adapter */

module bus_adapter (
    input  cache_pkg::line_t      line_in,
    input  rv32i_pkg::rv32i_word  wdata,
    input  logic [3:0]            byte_enable,
    input  logic [2:0]            word_sel,
    output cache_pkg::line_t      wdata_line,
    output rv32i_pkg::rv32i_word  rdata,
    output cache_pkg::line_be_t   byte_enable_line
);
    import cache_pkg::*;

    // every word slot carries the CPU word, enables pick the slot
    assign wdata_line = {8{wdata}};

    // addressed word of the selected line
    always_comb begin
        rdata = line_in[32*word_sel +: 32];
    end

    // four enables shifted to the word position
    always_comb begin
        byte_enable_line = line_be_t'(byte_enable) << (4 * word_sel);
    end

endmodule : bus_adapter

// File: src/cache_pkg.sv
/* Cache line and memory types */

package cache_pkg;

    // byte offset inside a 256-bit line
    localparam int offset_bits = 5;

    // tag field sized for a 3-bit index, the smallest one in use
    localparam int max_tag_bits = 32 - offset_bits - 3;

    typedef logic [255:0] line_t;

    // one enable per byte of a line
    typedef logic [31:0] line_be_t;

    // lookup result of a single way at the request index
    typedef struct packed {
        logic                    hit;
        logic                    valid;
        logic                    dirty;
        logic [max_tag_bits-1:0] tag;
    } way_status_t;

    // line memory request, held until pmem_resp
    typedef struct packed {
        logic                 read;
        logic                 write;
        rv32i_pkg::rv32i_word address;
        line_t                wdata;
    } pmem_req_t;

endpackage : cache_pkg

// File: src/rv32i_pkg.sv
/* CPU word and request types */

package rv32i_pkg;

    // one data or address word on the CPU side
    typedef logic [31:0] rv32i_word;

    // CPU request, held as a level until mem_resp
    typedef struct packed {
        logic       read;
        logic       write;
        logic [3:0] byte_enable;
        rv32i_word  address;
        rv32i_word  wdata;
    } mem_req_t;

endpackage : rv32i_pkg
